//--- common/decode_pkg.sv
// Decode package: shared widths, opcode and unit encodings, and the func record
`default_nettype none

package decode_pkg;

  // ====================
  // Widths
  // ====================
  localparam int ILEN      = 32;
  localparam int XLEN      = 32;
  localparam int REG_IDX_W = 5;
  localparam int UNIT_W    = 6;

  typedef logic [ILEN-1:0]      inst_t;
  typedef logic [XLEN-1:0]      xlen_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;

  // ====================
  // Major opcodes
  // ====================
  typedef enum logic [6:0] {
    LOAD     = 7'b0000011,
    CUSTOM0  = 7'b0001011,
    MISC_MEM = 7'b0001111,
    OP_IMM   = 7'b0010011,
    AUIPC    = 7'b0010111,
    STORE    = 7'b0100011,
    AMO      = 7'b0101111,
    OP       = 7'b0110011,
    LUI      = 7'b0110111,
    BRANCH   = 7'b1100011,
    JALR     = 7'b1100111,
    JAL      = 7'b1101111,
    SYSTEM   = 7'b1110011
  } opcode_e;

  // One-hot execution unit select
  typedef enum logic [UNIT_W-1:0] {
    UNIT_NONE = 6'b000000,
    ALU       = 6'b000001,
    MUL       = 6'b000010,
    DIV       = 6'b000100,
    BJU       = 6'b001000,
    LSU       = 6'b010000,
    CP0       = 6'b100000
  } unit_e;

  // Operation code seen by the execution units
  typedef struct packed {
    opcode_e    opcode;
    logic [2:0] funct3;
    logic       alt;     // instruction bit 30
  } func_t;

  // ====================
  // Field encodings
  // ====================
  localparam logic [6:0] FUNCT7_BASE   = 7'b0000000;
  localparam logic [6:0] FUNCT7_ALT    = 7'b0100000;
  localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

  // Privileged returns and wait, SYSTEM with funct3 000
  localparam logic [6:0] MRET_FUNCT7 = 7'b0011000;
  localparam logic [4:0] MRET_RS2    = 5'b00010;
  localparam logic [6:0] DRET_FUNCT7 = 7'b0111101;
  localparam logic [4:0] DRET_RS2    = 5'b10010;
  localparam logic [6:0] WFI_FUNCT7  = 7'b0001000;
  localparam logic [4:0] WFI_RS2     = 5'b00101;

  // Atomics
  localparam logic [2:0] AMO_FUNCT3 = 3'b010;
  localparam logic [4:0] LR_FUNCT5  = 5'b00010;
  localparam logic [4:0] SC_FUNCT5  = 5'b00011;

endpackage

`default_nettype wire

//--- common/decd_if.sv
// Decode packet interface: combinational decode result from decoder to dispatcher
`timescale 1ns/1ps
`default_nettype none

interface decd_if
  import decode_pkg::*;
();

  logic     vld;
  unit_e    unit;
  func_t    func;
  logic     ill;
  logic     inst_32bit;
  reg_idx_t rs1;
  logic     rs1_vld;
  reg_idx_t rs2;
  logic     rs2_vld;
  reg_idx_t rd;
  logic     rd_vld;
  xlen_t    imm;
  logic     imm_vld;
  xlen_t    inst_code;

  modport producer (
    output vld, unit, func, ill, inst_32bit,
    output rs1, rs1_vld, rs2, rs2_vld, rd, rd_vld,
    output imm, imm_vld, inst_code
  );

  modport consumer (
    input vld, unit, func, ill, inst_32bit,
    input rs1, rs1_vld, rs2, rs2_vld, rd, rd_vld,
    input imm, imm_vld, inst_code
  );

endinterface

`default_nettype wire

//--- decoder/inst_legality.sv
// Instruction legality: table check of a 32-bit instruction against mode and extension state
`timescale 1ns/1ps
`default_nettype none

module inst_legality
  import decode_pkg::*;
(
  input  inst_t inst,
  input  logic  mach_mode,
  input  logic  dbg_on,
  input  logic  isa_ext_en,
  output logic  ill
);

  opcode_e    op;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [4:0] rs2;
  logic [4:0] rd;
  logic       inst_32bit;
  logic       sync_form;
  logic       ok;

  assign op         = opcode_e'(inst[6:0]);
  assign funct3     = inst[14:12];
  assign funct7     = inst[31:25];
  assign rs2        = inst[24:20];
  assign rd         = inst[11:7];
  assign inst_32bit = &inst[1:0];
  // Cache sync form is the only one allowed outside machine or debug mode
  assign sync_form  = ~inst[25] & (inst[24:23] == 2'b11);

  // ====================
  // Legal table
  // ====================
  always_comb
  begin
    ok = 1'b0;
    case (op)
      OP:       ok = (funct7 == FUNCT7_BASE) | (funct7 == FUNCT7_MULDIV)
                   | ((funct7 == FUNCT7_ALT) & ((funct3 == 3'b000) | (funct3 == 3'b101)));
      OP_IMM:
      begin
        case (funct3)
          3'b001:  ok = (funct7 == FUNCT7_BASE);
          3'b101:  ok = (funct7 == FUNCT7_BASE) | (funct7 == FUNCT7_ALT);
          default: ok = 1'b1;
        endcase
      end
      LOAD:     ok = (funct3 != 3'b011) & (funct3 != 3'b110) & (funct3 != 3'b111);
      STORE:    ok = (funct3 == 3'b000) | (funct3 == 3'b001) | (funct3 == 3'b010);
      BRANCH:   ok = (funct3 != 3'b010) & (funct3 != 3'b011);
      JALR:     ok = (funct3 == 3'b000);
      MISC_MEM: ok = (funct3 == 3'b000) | (funct3 == 3'b001);
      LUI, AUIPC, JAL: ok = 1'b1;
      SYSTEM:
      begin
        if (funct3 == 3'b000)
          ok = ((funct7 == 7'b0) & (inst[24:21] == 4'b0))
             | ((funct7 == MRET_FUNCT7) & (rs2 == MRET_RS2))
             | ((funct7 == WFI_FUNCT7) & (rs2 == WFI_RS2))
             | ((funct7 == DRET_FUNCT7) & (rs2 == DRET_RS2) & dbg_on);
        else
          ok = (funct3 != 3'b100);
      end
      AMO:      ok = (funct3 == AMO_FUNCT3) & ((inst[31:29] == 3'b0) | (inst[28:27] == 2'b0));
      CUSTOM0:
      begin
        // Cache operations
        if ((funct3 == 3'b000) & (funct7[6:1] == 6'b0))
          ok = (rd == 5'b0) & (rs2 != 5'b0) & isa_ext_en
             & (sync_form | mach_mode | dbg_on);
      end
      default:  ok = 1'b0;
    endcase
  end

  assign ill = ~(inst_32bit & ok);

  // Legality resolves for every known instruction word
  a_ill_known: assert property (@(inst) $isunknown(inst) || !$isunknown(ill));

endmodule

`default_nettype wire

//--- decoder/inst_decoder.sv
// Instruction decoder: unit, func, operand and immediate decode of one instruction
`timescale 1ns/1ps
`default_nettype none

module inst_decoder
  import decode_pkg::*;
(
  input  logic inst_vld,
  input  inst_t inst,
  input  logic mach_mode,
  input  logic dbg_on,
  input  logic isa_ext_en,
  decd_if.producer dec
);

  opcode_e    op;
  logic [2:0] funct3;
  logic       tbl_ill;
  logic       inst_32bit;
  unit_e      unit_raw;
  unit_e      unit;
  logic       rs1_use;
  logic       rs2_use;
  logic       rd_use;
  xlen_t      imm;
  logic       imm_vld;

  assign op         = opcode_e'(inst[6:0]);
  assign funct3     = inst[14:12];
  assign inst_32bit = &inst[1:0];

  inst_legality u_legality (
    .inst       (inst),
    .mach_mode  (mach_mode),
    .dbg_on     (dbg_on),
    .isa_ext_en (isa_ext_en),
    .ill        (tbl_ill)
  );

  // ====================
  // Unit and operand use
  // ====================
  always_comb
  begin
    unit_raw = UNIT_NONE;
    rs1_use  = 1'b1;
    rs2_use  = 1'b0;
    rd_use   = 1'b0;
    case (op)
      OP:
      begin
        if (inst[31:25] == FUNCT7_MULDIV)
          unit_raw = funct3[2] ? DIV : MUL;
        else
          unit_raw = ALU;
        rs2_use = 1'b1;
        rd_use  = 1'b1;
      end
      OP_IMM, LOAD, JALR:
      begin
        unit_raw = (op == OP_IMM) ? ALU : (op == LOAD) ? LSU : BJU;
        rd_use   = 1'b1;
      end
      LUI, AUIPC, JAL:
      begin
        unit_raw = (op == LUI) ? ALU : BJU;
        rs1_use  = 1'b0;
        rd_use   = 1'b1;
      end
      STORE, CUSTOM0:
      begin
        unit_raw = LSU;
        rs2_use  = 1'b1;
      end
      BRANCH:
      begin
        unit_raw = BJU;
        rs2_use  = 1'b1;
      end
      AMO:
      begin
        unit_raw = LSU;
        rs2_use  = 1'b1;
        rd_use   = 1'b1;
      end
      MISC_MEM:
      begin
        unit_raw = LSU;
        rs1_use  = 1'b0;
      end
      SYSTEM:
      begin
        unit_raw = CP0;
        // Only register-form CSR accesses read rs1
        rs1_use  = (funct3 == 3'b001) | (funct3 == 3'b010) | (funct3 == 3'b011);
        rd_use   = (funct3 != 3'b000);
      end
      default: unit_raw = UNIT_NONE;
    endcase
  end

  assign unit = tbl_ill ? UNIT_NONE : unit_raw;

  // ====================
  // Immediate
  // ====================
  always_comb
  begin
    imm_vld = 1'b1;
    case (op)
      LOAD, OP_IMM, JALR: imm = {{20{inst[31]}}, inst[31:20]};
      STORE:              imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      BRANCH:   imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
      LUI, AUIPC:         imm = {inst[31:12], 12'b0};
      JAL:      imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
      default:
      begin
        imm     = '0;
        imm_vld = 1'b0;
      end
    endcase
  end

  // Packet to the dispatcher
  assign dec.vld        = inst_vld;
  assign dec.unit       = unit;
  // Any jump or branch in debug mode traps, unit kept as BJU
  assign dec.ill        = tbl_ill | ((unit == BJU) & dbg_on);
  assign dec.func       = '{opcode: op, funct3: funct3, alt: inst[30]};
  assign dec.inst_32bit = inst_32bit;
  assign dec.rs1        = inst[19:15];
  assign dec.rs2        = inst[24:20];
  assign dec.rd         = inst[11:7];
  assign dec.rs1_vld    = rs1_use & ~tbl_ill;
  assign dec.rs2_vld    = rs2_use & ~tbl_ill;
  assign dec.rd_vld     = rd_use & ~tbl_ill;
  assign dec.imm        = imm;
  assign dec.imm_vld    = imm_vld;
  assign dec.inst_code  = {{16{inst_32bit}} & inst[31:16], inst[15:0]};

  // Table and unit map agree on what is executable
  a_legal_has_unit: assert property (@(inst) !tbl_ill |-> (unit != UNIT_NONE));

endmodule

`default_nettype wire

//--- design/decode_dispatch.sv
// Decode dispatch: pipeline register and output formatting of the decode packet
`timescale 1ns/1ps
`default_nettype none

module decode_dispatch
  import decode_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  decd_if.consumer dec,
  output logic     out_vld,
  output unit_e    unit_sel,
  output func_t    func,
  output logic     ill_expt,
  output logic     inst_32bit,
  output reg_idx_t rs1_idx,
  output reg_idx_t rs2_idx,
  output reg_idx_t rd_idx,
  output logic     rs1_vld,
  output logic     rs2_vld,
  output logic     rd_vld,
  output xlen_t    imm,
  output logic     imm_vld,
  output xlen_t    ag_imm,
  output logic     ag_imm_vld,
  output logic     bju_use_pc,
  output logic     lsu_sel,
  output logic     csri_vld,
  output logic     split_req
);

  xlen_t      inst_code;
  logic [4:0] funct5;
  logic       aqrl;

  // ====================
  // Pipeline register
  // ====================
  always_ff @(posedge clk)
  begin
    if (rst)
      out_vld <= 1'b0;
    else
      out_vld <= dec.vld;
  end

  always_ff @(posedge clk)
  begin
    unit_sel   <= dec.unit;
    func       <= dec.func;
    ill_expt   <= dec.ill;
    inst_32bit <= dec.inst_32bit;
    rs1_idx    <= dec.rs1;
    rs2_idx    <= dec.rs2;
    rd_idx     <= dec.rd;
    rs1_vld    <= dec.rs1_vld;
    rs2_vld    <= dec.rs2_vld;
    rd_vld     <= dec.rd_vld;
    imm        <= dec.imm;
    imm_vld    <= dec.imm_vld;
    inst_code  <= dec.inst_code;
  end

  // ====================
  // Output formatting
  // ====================
  // Illegal and CP0 instructions carry their raw code to the trap and CSR paths
  assign ag_imm_vld = (unit_sel == BJU) | (unit_sel == LSU) | (unit_sel == CP0) | ill_expt;
  assign ag_imm     = (ill_expt | (unit_sel == CP0)) ? inst_code : imm;
  assign bju_use_pc = (unit_sel == BJU) & (func.opcode != JALR);
  assign lsu_sel    = (unit_sel == LSU);
  assign csri_vld   = (unit_sel == CP0) & func.funct3[2];

  // AMO splits unless it is a plain LR or SC
  assign funct5    = inst_code[31:27];
  assign aqrl      = |inst_code[26:25];
  assign split_req = out_vld & ~ill_expt & (func.opcode == AMO)
                   & (((funct5 != LR_FUNCT5) & (funct5 != SC_FUNCT5)) | aqrl);

  a_unit_onehot: assert property (@(posedge clk) disable iff (rst)
    out_vld |-> $onehot0(unit_sel));

  a_split_is_lsu: assert property (@(posedge clk) disable iff (rst)
    split_req |-> lsu_sel);

endmodule

`default_nettype wire

//--- design/decode_stage.sv
// Decode stage top: instruction decoder and dispatch register behind plain ports
`timescale 1ns/1ps
`default_nettype none

module decode_stage
  import decode_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     inst_vld,
  input  inst_t    inst,
  input  logic     mach_mode,
  input  logic     dbg_on,
  input  logic     isa_ext_en,
  output logic     out_vld,
  output unit_e    unit_sel,
  output func_t    func,
  output logic     ill_expt,
  output logic     inst_32bit,
  output reg_idx_t rs1_idx,
  output reg_idx_t rs2_idx,
  output reg_idx_t rd_idx,
  output logic     rs1_vld,
  output logic     rs2_vld,
  output logic     rd_vld,
  output xlen_t    imm,
  output logic     imm_vld,
  output xlen_t    ag_imm,
  output logic     ag_imm_vld,
  output logic     bju_use_pc,
  output logic     lsu_sel,
  output logic     csri_vld,
  output logic     split_req
);

  decd_if u_dec_if ();

  inst_decoder u_decoder (
    .inst_vld   (inst_vld),
    .inst       (inst),
    .mach_mode  (mach_mode),
    .dbg_on     (dbg_on),
    .isa_ext_en (isa_ext_en),
    .dec        (u_dec_if.producer)
  );

  decode_dispatch u_dispatch (
    .clk        (clk),
    .rst        (rst),
    .dec        (u_dec_if.consumer),
    .out_vld    (out_vld),
    .unit_sel   (unit_sel),
    .func       (func),
    .ill_expt   (ill_expt),
    .inst_32bit (inst_32bit),
    .rs1_idx    (rs1_idx),
    .rs2_idx    (rs2_idx),
    .rd_idx     (rd_idx),
    .rs1_vld    (rs1_vld),
    .rs2_vld    (rs2_vld),
    .rd_vld     (rd_vld),
    .imm        (imm),
    .imm_vld    (imm_vld),
    .ag_imm     (ag_imm),
    .ag_imm_vld (ag_imm_vld),
    .bju_use_pc (bju_use_pc),
    .lsu_sel    (lsu_sel),
    .csri_vld   (csri_vld),
    .split_req  (split_req)
  );

endmodule

`default_nettype wire

//--- bench/tb_ref_model.svh
// Reference decode model: expected stage outputs for one instruction word
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

typedef struct packed {
  unit_e    unit;
  func_t    func;
  logic     ill;
  logic     inst_32bit;
  reg_idx_t rs1;
  reg_idx_t rs2;
  reg_idx_t rd;
  logic     rs1_vld;
  logic     rs2_vld;
  logic     rd_vld;
  xlen_t    imm;
  logic     imm_vld;
  xlen_t    ag_imm;
  logic     ag_imm_vld;
  logic     bju_use_pc;
  logic     lsu_sel;
  logic     csri_vld;
  logic     split_req;
} exp_t;

function automatic exp_t decode_ref(input inst_t w, input logic mm, input logic dbg,
                                    input logic ext);
  exp_t       e;
  opcode_e    op;
  logic [6:0] f7;
  logic [2:0] f3;
  logic [4:0] f5;
  logic       ok;
  xlen_t      code;

  op = opcode_e'(w[6:0]);
  f7 = w[31:25];
  f3 = w[14:12];
  f5 = w[31:27];
  e  = '0;

  // ====================
  // Legal instructions
  // ====================
  case (op)
    OP:       ok = (f7 == FUNCT7_BASE) || (f7 == FUNCT7_MULDIV)
                   || ((f7 == FUNCT7_ALT) && (f3 inside {3'd0, 3'd5}));
    OP_IMM:   ok = (f3 == 3'd1) ? (f7 == FUNCT7_BASE)
                 : ((f3 == 3'd5) ? (f7 inside {FUNCT7_BASE, FUNCT7_ALT}) : 1'b1);
    LOAD:     ok = f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
    STORE:    ok = f3 inside {3'd0, 3'd1, 3'd2};
    BRANCH:   ok = !(f3 inside {3'd2, 3'd3});
    JALR:     ok = (f3 == 3'd0);
    MISC_MEM: ok = f3 inside {3'd0, 3'd1};
    LUI, AUIPC, JAL: ok = 1'b1;
    SYSTEM:   ok = (f3 != 3'd0) ? (f3 != 3'd4)
                 : (((f7 == 7'd0) && (w[24:21] == 4'd0))
                   || ((f7 == MRET_FUNCT7) && (w[24:20] == MRET_RS2))
                   || ((f7 == WFI_FUNCT7) && (w[24:20] == WFI_RS2))
                   || ((f7 == DRET_FUNCT7) && (w[24:20] == DRET_RS2) && dbg));
    AMO:      ok = (f3 == AMO_FUNCT3) && ((w[31:29] == 3'd0) || (w[28:27] == 2'd0));
    // Cache ops, only the sync form is open to user mode
    CUSTOM0:  ok = (f3 == 3'd0) && (f7[6:1] == 6'd0) && (w[11:7] == 5'd0)
                   && (w[24:20] != 5'd0) && ext
                   && ((!w[25] && (w[24:23] == 2'b11)) || mm || dbg);
    default:  ok = 1'b0;
  endcase
  ok = ok && (w[1:0] == 2'b11);

  case (op)
    OP:                                  e.unit = (f7 != FUNCT7_MULDIV) ? ALU
                                                : (f3[2] ? DIV : MUL);
    OP_IMM, LUI:                         e.unit = ALU;
    BRANCH, JAL, JALR, AUIPC:            e.unit = BJU;
    LOAD, STORE, AMO, MISC_MEM, CUSTOM0: e.unit = LSU;
    SYSTEM:                              e.unit = CP0;
    default:                             e.unit = UNIT_NONE;
  endcase
  if (!ok)
    e.unit = UNIT_NONE;

  e.ill        = !ok || ((e.unit == BJU) && dbg);
  e.func       = '{opcode: op, funct3: f3, alt: w[30]};
  e.inst_32bit = (w[1:0] == 2'b11);
  e.rs1        = w[19:15];
  e.rs2        = w[24:20];
  e.rd         = w[11:7];
  e.rs1_vld    = ok && ((op == SYSTEM) ? (f3 inside {3'd1, 3'd2, 3'd3})
                                       : !(op inside {LUI, AUIPC, JAL, MISC_MEM}));
  e.rs2_vld    = ok && (op inside {OP, STORE, BRANCH, AMO, CUSTOM0});
  e.rd_vld     = ok && ((op inside {OP, OP_IMM, LOAD, LUI, AUIPC, JAL, JALR, AMO})
                        || ((op == SYSTEM) && (f3 != 3'd0)));

  // Immediate formats, sign taken from bit 31 by arithmetic shift
  e.imm_vld = 1'b1;
  case (op)
    LOAD, OP_IMM, JALR: e.imm = $signed({w[31:20], 20'd0}) >>> 20;
    STORE:              e.imm = $signed({w[31:25], w[11:7], 20'd0}) >>> 20;
    BRANCH:   e.imm = $signed({w[31], w[7], w[30:25], w[11:8], 1'b0, 19'd0}) >>> 19;
    LUI, AUIPC:         e.imm = {w[31:12], 12'd0};
    JAL:      e.imm = $signed({w[31], w[19:12], w[20], w[30:21], 1'b0, 11'd0}) >>> 11;
    default:            e.imm_vld = 1'b0;
  endcase

  // ====================
  // Dispatch outputs
  // ====================
  code         = e.inst_32bit ? w : {16'd0, w[15:0]};
  e.ag_imm_vld = (e.unit inside {BJU, LSU, CP0}) || e.ill;
  e.ag_imm     = (e.ill || (e.unit == CP0)) ? code : e.imm;
  e.bju_use_pc = (e.unit == BJU) && (op != JALR);
  e.lsu_sel    = (e.unit == LSU);
  e.csri_vld   = (e.unit == CP0) && f3[2];
  e.split_req  = !e.ill && (op == AMO)
                 && (!(f5 inside {LR_FUNCT5, SC_FUNCT5}) || (w[26:25] != 2'd0));
  return e;
endfunction

`endif

//--- bench/tb_decode_stage.sv
// Decode stage testbench: random and directed instructions checked against a reference model
`timescale 1ns/1ps
`default_nettype none

module tb_decode_stage
  import decode_pkg::*;
();

  `include "tb_ref_model.svh"

  logic     clk;
  logic     rst;
  logic     inst_vld;
  inst_t    inst;
  logic     mach_mode;
  logic     dbg_on;
  logic     isa_ext_en;
  logic     out_vld;
  unit_e    unit_sel;
  func_t    func;
  logic     ill_expt;
  logic     inst_32bit;
  reg_idx_t rs1_idx;
  reg_idx_t rs2_idx;
  reg_idx_t rd_idx;
  logic     rs1_vld;
  logic     rs2_vld;
  logic     rd_vld;
  xlen_t    imm;
  logic     imm_vld;
  xlen_t    ag_imm;
  logic     ag_imm_vld;
  logic     bju_use_pc;
  logic     lsu_sel;
  logic     csri_vld;
  logic     split_req;

  // Expected results with the cycle of their strobe
  exp_t        exp_q[$];
  int          cyc_q[$];
  int          cyc = 0;
  logic [63:0] lcg_state = 64'd23889;
  opcode_e     op_list [13] = '{LOAD, MISC_MEM, OP_IMM, AUIPC, STORE, AMO, OP, LUI,
                                BRANCH, JALR, JAL, SYSTEM, CUSTOM0};

  decode_stage dut (.*);

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk)
    cyc <= cyc + 1;

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 64'd6364136223846793005 + 64'd1442695040888963407;
    return lcg_state[63:32];
  endfunction

  // ====================
  // Checks
  // ====================
  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  task automatic unit_check(input string name, input unit_e got, input unit_e exp);
    if (got !== exp)
      report_fail($sformatf("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  task automatic func_check(input string name, input func_t got, input func_t exp);
    if (got !== exp)
      report_fail($sformatf("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  task automatic idx_check(input string name, input reg_idx_t got, input reg_idx_t exp);
    if (got !== exp)
      report_fail($sformatf("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  task automatic word_check(input string name, input xlen_t got, input xlen_t exp);
    if (got !== exp)
      report_fail($sformatf("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  task automatic bit_check(input string name, input logic got, input logic exp);
    if (got !== exp)
      report_fail($sformatf("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  task automatic compare_result(input exp_t e);
    unit_check("unit_sel", unit_sel, e.unit);
    func_check("func", func, e.func);
    bit_check("ill_expt", ill_expt, e.ill);
    bit_check("inst_32bit", inst_32bit, e.inst_32bit);
    idx_check("rs1_idx", rs1_idx, e.rs1);
    idx_check("rs2_idx", rs2_idx, e.rs2);
    idx_check("rd_idx", rd_idx, e.rd);
    bit_check("rs1_vld", rs1_vld, e.rs1_vld);
    bit_check("rs2_vld", rs2_vld, e.rs2_vld);
    bit_check("rd_vld", rd_vld, e.rd_vld);
    word_check("imm", imm, e.imm);
    bit_check("imm_vld", imm_vld, e.imm_vld);
    word_check("ag_imm", ag_imm, e.ag_imm);
    bit_check("ag_imm_vld", ag_imm_vld, e.ag_imm_vld);
    bit_check("bju_use_pc", bju_use_pc, e.bju_use_pc);
    bit_check("lsu_sel", lsu_sel, e.lsu_sel);
    bit_check("csri_vld", csri_vld, e.csri_vld);
    bit_check("split_req", split_req, e.split_req);
  endtask

  // Outputs are registered, so the falling edge sees them settled
  initial
  begin
    exp_t e;
    int   issued;
    forever
    begin
      @(negedge clk);
      if (rst)
      begin
        bit_check("out_vld", out_vld, 1'b0);
        bit_check("split_req", split_req, 1'b0);
      end
      else if (out_vld === 1'b1)
      begin
        if (exp_q.size() == 0)
          report_fail("out_vld pulsed with no instruction pending");
        e      = exp_q.pop_front();
        issued = cyc_q.pop_front();
        if (cyc != issued + 1)
          report_fail("result did not arrive exactly one cycle after its strobe");
        compare_result(e);
      end
      else
      begin
        bit_check("out_vld", out_vld, 1'b0);
        bit_check("split_req", split_req, 1'b0);
        if ((cyc_q.size() != 0) && (cyc_q[0] < cyc))
          report_fail("no result one cycle after an instruction strobe");
      end
    end
  end

  // ====================
  // Stimulus
  // ====================
  task automatic drive_inst(input inst_t w, input logic mm, input logic dbg,
                            input logic ext);
    @(negedge clk);
    inst_vld   = 1'b1;
    inst       = w;
    mach_mode  = mm;
    dbg_on     = dbg;
    isa_ext_en = ext;
    exp_q.push_back(decode_ref(w, mm, dbg, ext));
    cyc_q.push_back(cyc);
  endtask

  task automatic idle_cycle();
    @(negedge clk);
    inst_vld = 1'b0;
    inst     = next_rand();
  endtask

  // Known opcodes with random fields, mixed with fully random words
  task automatic random_stream(input int count, input logic gaps);
    logic [31:0] r;
    logic [31:0] f;
    inst_t       w;
    int          k;
    int          n;
    for (n = 0; n < count; n++)
    begin
      r = next_rand();
      f = next_rand();
      k = int'(r[31:16] % 16'd13);
      w = (r[7:6] == 2'd0) ? f : {f[31:7], op_list[k]};
      case (r[11:9])
        3'd1:    w[31:25] = FUNCT7_BASE;
        3'd2:    w[31:25] = FUNCT7_ALT;
        3'd3:    w[31:25] = FUNCT7_MULDIV;
        default: ;
      endcase
      drive_inst(w, r[0], r[1] & r[2], r[3] | r[4]);
      if (gaps & r[8] & r[5])
        idle_cycle();
    end
  endtask

  initial
  begin
    logic [31:0] r;
    int          i;
    rst        = 1'b1;
    inst_vld   = 1'b0;
    inst       = '0;
    mach_mode  = 1'b0;
    dbg_on     = 1'b0;
    isa_ext_en = 1'b0;

    // Strobes during reset are dropped
    for (i = 0; i < 16; i++)
    begin
      @(negedge clk);
      r        = next_rand();
      inst     = r;
      inst_vld = (i < 12) ? r[0] : 1'b0;
    end
    rst = 1'b0;
    idle_cycle();

    random_stream(400, 1'b1);

    // 16-bit words
    drive_inst(32'h1234_4501, 1'b1, 1'b0, 1'b1);
    drive_inst(32'hdead_beee, 1'b0, 1'b0, 1'b0);
    drive_inst(32'h8000_0002, 1'b0, 1'b1, 1'b1);
    idle_cycle();

    // Returns, wait and CSR accesses
    drive_inst({DRET_FUNCT7, DRET_RS2, 5'd0, 3'd0, 5'd0, SYSTEM}, 1'b1, 1'b0, 1'b0);
    drive_inst({DRET_FUNCT7, DRET_RS2, 5'd0, 3'd0, 5'd0, SYSTEM}, 1'b1, 1'b1, 1'b0);
    drive_inst({MRET_FUNCT7, MRET_RS2, 5'd0, 3'd0, 5'd0, SYSTEM}, 1'b1, 1'b0, 1'b0);
    drive_inst({MRET_FUNCT7, 5'd3, 5'd0, 3'd0, 5'd0, SYSTEM}, 1'b1, 1'b0, 1'b0);
    drive_inst({WFI_FUNCT7, WFI_RS2, 5'd0, 3'd0, 5'd0, SYSTEM}, 1'b0, 1'b0, 1'b0);
    drive_inst({WFI_FUNCT7, 5'd4, 5'd0, 3'd0, 5'd0, SYSTEM}, 1'b0, 1'b0, 1'b0);
    drive_inst({12'h300, 5'd7, 3'b101, 5'd1, SYSTEM}, 1'b1, 1'b0, 1'b0);
    drive_inst({12'h341, 5'd7, 3'b010, 5'd1, SYSTEM}, 1'b1, 1'b0, 1'b0);

    // Jumps and branches trap in debug mode
    r = next_rand();
    drive_inst({r[31:7], JAL}, 1'b0, 1'b1, 1'b0);
    drive_inst({r[31:15], 3'd0, r[11:7], JALR}, 1'b0, 1'b1, 1'b0);
    drive_inst({r[31:15], 3'd1, r[11:7], BRANCH}, 1'b0, 1'b1, 1'b0);
    drive_inst({r[31:7], AUIPC}, 1'b0, 1'b1, 1'b0);
    idle_cycle();

    // Atomics
    drive_inst({5'b00000, 2'b00, 5'd2, 5'd1, AMO_FUNCT3, 5'd3, AMO}, 1'b0, 1'b0, 1'b0);
    drive_inst({LR_FUNCT5, 2'b00, 5'd0, 5'd1, AMO_FUNCT3, 5'd3, AMO}, 1'b0, 1'b0, 1'b0);
    drive_inst({LR_FUNCT5, 2'b10, 5'd0, 5'd1, AMO_FUNCT3, 5'd3, AMO}, 1'b0, 1'b0, 1'b0);
    drive_inst({SC_FUNCT5, 2'b01, 5'd2, 5'd1, AMO_FUNCT3, 5'd3, AMO}, 1'b0, 1'b0, 1'b0);
    drive_inst({SC_FUNCT5, 2'b00, 5'd2, 5'd1, AMO_FUNCT3, 5'd3, AMO}, 1'b0, 1'b0, 1'b0);

    // Cache operations, sync form first
    drive_inst({7'd0, 5'b11000, 5'd4, 3'd0, 5'd0, CUSTOM0}, 1'b0, 1'b0, 1'b1);
    drive_inst({7'd0, 5'b11000, 5'd4, 3'd0, 5'd0, CUSTOM0}, 1'b0, 1'b0, 1'b0);
    drive_inst({7'd1, 5'b00101, 5'd4, 3'd0, 5'd0, CUSTOM0}, 1'b0, 1'b0, 1'b1);
    drive_inst({7'd1, 5'b00101, 5'd4, 3'd0, 5'd0, CUSTOM0}, 1'b1, 1'b0, 1'b1);
    drive_inst({7'd1, 5'b00101, 5'd4, 3'd0, 5'd0, CUSTOM0}, 1'b0, 1'b1, 1'b1);
    drive_inst({7'd0, 5'b11000, 5'd4, 3'd0, 5'd6, CUSTOM0}, 1'b1, 1'b0, 1'b1);
    drive_inst({7'd0, 5'd0, 5'd4, 3'd0, 5'd0, CUSTOM0}, 1'b1, 1'b0, 1'b1);
    idle_cycle();

    // Back-to-back strobes
    random_stream(32, 1'b0);
    idle_cycle();

    for (i = 0; (i < 20) && (exp_q.size() != 0); i++)
      @(negedge clk);
    if (exp_q.size() != 0)
      report_fail("timed out waiting for the last results");
    else
    begin
      $display("=== PASS ===");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+bench
common/decode_pkg.sv
common/decd_if.sv
decoder/inst_legality.sv
decoder/inst_decoder.sv
design/decode_dispatch.sv
design/decode_stage.sv
bench/tb_decode_stage.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -f flist.f --top-module tb_decode_stage \
       -o sim_decode_stage \
  && ./obj_dir/sim_decode_stage \
  || exit 1
